// ==== logic/dcache_ctrl.sv ====
module dcache_ctrl (
    input  logic                          clk_i,
    input  logic                          rst_i,
    // Processor side
    input  logic                          p_strobe_i,
    input  dcache_pkg::cpu_req_t          p_req_i,
    output logic                          p_ready_o,
    output dcache_pkg::word_t             p_rdata_o,
    // Memory side
    output logic                          m_strobe_o,
    output dcache_pkg::mem_req_t          m_req_o,
    input  logic                          m_ready_i,
    input  dcache_pkg::line_t             m_rdata_i,
    // To all ways
    output dcache_pkg::set_idx_t          set_o,
    output dcache_pkg::tag_t              tag_o,
    output logic [dcache_pkg::N_WAYS-1:0] way_we_o,
    output dcache_pkg::line_t             wr_line_o,
    output logic                          wr_dirty_o,
    // From way select
    input  logic                          hit_i,
    input  dcache_pkg::way_idx_t          hit_way_i,
    input  dcache_pkg::word_t             rd_word_i,
    input  dcache_pkg::line_t             merge_line_i,
    input  dcache_pkg::line_t             victim_line_i,
    input  dcache_pkg::way_status_t       victim_status_i,
    // To way select
    output dcache_pkg::way_idx_t          victim_way_o,
    output dcache_pkg::word_off_t         word_off_o,
    output dcache_pkg::byte_en_t          byte_en_o,
    output dcache_pkg::word_t             wdata_o,
    output dcache_pkg::line_t             refill_line_o,
    output logic                          use_refill_o
);

    dcache_pkg::ctrl_state_e state_q, state_d;
    dcache_pkg::cpu_req_t    req_q;        // Request under service
    dcache_pkg::line_t       refill_q;     // Line returned by memory
    logic                    miss_q;       // Access went through refill
    dcache_pkg::way_idx_t    fifo_q [dcache_pkg::N_SETS];  // Next victim per set
    dcache_pkg::set_idx_t    req_set;
    dcache_pkg::tag_t        req_tag;
    logic                    mem_phase;

    assign req_set   = req_q.addr[dcache_pkg::SET_LSB +: dcache_pkg::SET_W];
    assign req_tag   = req_q.addr[dcache_pkg::TAG_LSB +: dcache_pkg::TAG_W];
    assign mem_phase = (state_q == dcache_pkg::ST_WRITE_BACK) ||
                       (state_q == dcache_pkg::ST_REFILL);

    // ==========================================================
    // Miss / write-back FSM
    // ==========================================================
    always_comb
    begin
        state_d = state_q;
        case (state_q)
            dcache_pkg::ST_IDLE:
                if (p_strobe_i)
                    state_d = dcache_pkg::ST_LOOKUP;
            dcache_pkg::ST_LOOKUP:  // Way outputs valid here
                if (hit_i)
                    state_d = dcache_pkg::ST_UPDATE;
                else if (victim_status_i.dirty)
                    state_d = dcache_pkg::ST_WRITE_BACK;
                else
                    state_d = dcache_pkg::ST_REFILL;
            dcache_pkg::ST_WRITE_BACK:
                if (m_strobe_o && m_ready_i)
                    state_d = dcache_pkg::ST_REFILL;
            dcache_pkg::ST_REFILL:
                if (m_strobe_o && m_ready_i)
                    state_d = dcache_pkg::ST_UPDATE;
            default:  // ST_UPDATE lasts one cycle
                state_d = dcache_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            state_q    <= dcache_pkg::ST_IDLE;
            m_strobe_o <= 1'b0;
            miss_q     <= 1'b0;
        end
        else
        begin
            state_q <= state_d;
            if (state_q == dcache_pkg::ST_LOOKUP)
                miss_q <= !hit_i;
            if (mem_phase && !m_strobe_o)  // Raise once per memory phase
                m_strobe_o <= 1'b1;
            else if (m_ready_i)
                m_strobe_o <= 1'b0;
        end
    end

    // FIFO replacement, counter moves when the refilled line is written
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            for (int s = 0; s < dcache_pkg::N_SETS; s++)
                fifo_q[s] <= '0;
        end
        else if (state_q == dcache_pkg::ST_UPDATE && miss_q)
            fifo_q[req_set] <= fifo_q[req_set] + dcache_pkg::way_idx_t'(1);
    end

    // ==========================================================
    // Request and memory payload
    // ==========================================================
    always_ff @(posedge clk_i)
    begin
        if (state_q == dcache_pkg::ST_IDLE && p_strobe_i)
            req_q <= p_req_i;
        if (state_q == dcache_pkg::ST_REFILL && m_ready_i)
            refill_q <= m_rdata_i;
        if (mem_phase && !m_strobe_o)  // Loaded with the strobe, held till ready
        begin
            if (state_q == dcache_pkg::ST_WRITE_BACK)
            begin
                m_req_o.rw   <= 1'b1;
                m_req_o.addr <= {victim_status_i.tag, req_set, {dcache_pkg::SET_LSB{1'b0}}};
                m_req_o.line <= victim_line_i;
            end
            else
            begin
                m_req_o.rw   <= 1'b0;
                m_req_o.addr <= {req_q.addr[dcache_pkg::XLEN-1:dcache_pkg::SET_LSB],
                                 {dcache_pkg::SET_LSB{1'b0}}};
                m_req_o.line <= '0;
            end
        end
    end

    // Way write on write hit or after any refill
    always_comb
    begin
        way_we_o = '0;
        if (state_q == dcache_pkg::ST_UPDATE)
        begin
            if (miss_q)
                way_we_o[fifo_q[req_set]] = 1'b1;
            else if (req_q.rw)
                way_we_o[hit_way_i] = 1'b1;
        end
    end

    // Lookup address straight from the processor while idle
    assign set_o = (state_q == dcache_pkg::ST_IDLE) ?
                   p_req_i.addr[dcache_pkg::SET_LSB +: dcache_pkg::SET_W] : req_set;
    assign tag_o = (state_q == dcache_pkg::ST_IDLE) ?
                   p_req_i.addr[dcache_pkg::TAG_LSB +: dcache_pkg::TAG_W] : req_tag;

    assign wr_line_o     = merge_line_i;  // Plain refill line for reads
    assign wr_dirty_o    = req_q.rw;
    assign victim_way_o  = fifo_q[req_set];
    assign word_off_o    = req_q.addr[dcache_pkg::BYTE_OFF_W +: dcache_pkg::WORD_OFF_W];
    assign byte_en_o     = req_q.rw ? req_q.byte_en : '0;  // Reads merge nothing
    assign wdata_o       = req_q.wdata;
    assign refill_line_o = refill_q;
    assign use_refill_o  = miss_q;

    assign p_ready_o = (state_q == dcache_pkg::ST_UPDATE);
    assign p_rdata_o = rd_word_i;

endmodule

// ==== logic/dcache_pkg.sv ====
package dcache_pkg;

    // ==========================================================
    // Cache geometry
    // ==========================================================
    localparam int XLEN           = 32;  // Word width
    localparam int WORDS_PER_LINE = 8;
    localparam int LINE_W         = XLEN * WORDS_PER_LINE;  // 256 bits
    localparam int N_WAYS         = 4;
    localparam int N_SETS         = 16;
    localparam int BYTE_OFF_W     = 2;
    localparam int WORD_OFF_W     = 3;
    localparam int SET_W          = 4;
    localparam int TAG_W          = XLEN - SET_W - WORD_OFF_W - BYTE_OFF_W;  // 23
    localparam int WAY_W          = 2;

    // Field positions inside a byte address
    localparam int SET_LSB        = BYTE_OFF_W + WORD_OFF_W;  // Also the line offset width
    localparam int TAG_LSB        = SET_LSB + SET_W;

    // ==========================================================
    // Vector types
    // ==========================================================
    typedef logic [XLEN-1:0]       word_t;
    typedef logic [LINE_W-1:0]     line_t;      // Word 0 sits in the top 32 bits
    typedef logic [XLEN-1:0]       addr_t;
    typedef logic [TAG_W-1:0]      tag_t;
    typedef logic [SET_W-1:0]      set_idx_t;
    typedef logic [WORD_OFF_W-1:0] word_off_t;
    typedef logic [WAY_W-1:0]      way_idx_t;
    typedef logic [XLEN/8-1:0]     byte_en_t;   // Bit 0 enables bits 7:0

    // Processor request, held by the controller for the whole access
    typedef struct packed {
        logic     rw;       // 0 read, 1 write
        byte_en_t byte_en;
        addr_t    addr;
        word_t    wdata;
    } cpu_req_t;

    // Memory request, one whole line per transfer
    typedef struct packed {
        logic  rw;          // 0 refill read, 1 write-back
        addr_t addr;        // Line aligned
        line_t line;        // Write-back data
    } mem_req_t;

    typedef struct packed {
        logic hit;
        logic dirty;
        tag_t tag;
    } way_status_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_WRITE_BACK,
        ST_REFILL,
        ST_UPDATE
    } ctrl_state_e;

endpackage

// ==== logic/dcache_top.sv ====
module dcache_top (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 p_strobe_i,
    input  dcache_pkg::cpu_req_t p_req_i,
    output logic                 p_ready_o,
    output dcache_pkg::word_t    p_rdata_o,
    output logic                 m_strobe_o,
    output dcache_pkg::mem_req_t m_req_o,
    input  logic                 m_ready_i,
    input  dcache_pkg::line_t    m_rdata_i
);

    // ==========================================================
    // Controller to ways
    // ==========================================================
    dcache_pkg::set_idx_t          way_set;
    dcache_pkg::tag_t              way_tag;
    logic [dcache_pkg::N_WAYS-1:0] way_we;
    dcache_pkg::line_t             wr_line;
    logic                          wr_dirty;

    // Ways to way select
    dcache_pkg::way_status_t way_status [dcache_pkg::N_WAYS];
    dcache_pkg::line_t       way_line   [dcache_pkg::N_WAYS];

    // Way select and controller
    logic                    hit;
    dcache_pkg::way_idx_t    hit_way;
    dcache_pkg::word_t       rd_word;
    dcache_pkg::line_t       merge_line;
    dcache_pkg::line_t       victim_line;
    dcache_pkg::way_status_t victim_status;
    dcache_pkg::way_idx_t    victim_way;
    dcache_pkg::word_off_t   word_off;
    dcache_pkg::byte_en_t    byte_en;
    dcache_pkg::word_t       wdata;
    dcache_pkg::line_t       refill_line;
    logic                    use_refill;

    dcache_ctrl u_ctrl (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .p_strobe_i      (p_strobe_i),
        .p_req_i         (p_req_i),
        .p_ready_o       (p_ready_o),
        .p_rdata_o       (p_rdata_o),
        .m_strobe_o      (m_strobe_o),
        .m_req_o         (m_req_o),
        .m_ready_i       (m_ready_i),
        .m_rdata_i       (m_rdata_i),
        .set_o           (way_set),
        .tag_o           (way_tag),
        .way_we_o        (way_we),
        .wr_line_o       (wr_line),
        .wr_dirty_o      (wr_dirty),
        .hit_i           (hit),
        .hit_way_i       (hit_way),
        .rd_word_i       (rd_word),
        .merge_line_i    (merge_line),
        .victim_line_i   (victim_line),
        .victim_status_i (victim_status),
        .victim_way_o    (victim_way),
        .word_off_o      (word_off),
        .byte_en_o       (byte_en),
        .wdata_o         (wdata),
        .refill_line_o   (refill_line),
        .use_refill_o    (use_refill)
    );

    // One instance per way, shared address and write data
    generate
        for (genvar g = 0; g < dcache_pkg::N_WAYS; g++)
        begin : g_way
            dcache_way u_way (
                .clk_i    (clk_i),
                .rst_i    (rst_i),
                .set_i    (way_set),
                .tag_i    (way_tag),
                .we_i     (way_we[g]),
                .line_i   (wr_line),
                .dirty_i  (wr_dirty),
                .status_o (way_status[g]),
                .line_o   (way_line[g])
            );
        end
    endgenerate

    dcache_way_select u_sel (
        .statuses_i      (way_status),
        .lines_i         (way_line),
        .victim_way_i    (victim_way),
        .word_off_i      (word_off),
        .byte_en_i       (byte_en),
        .wdata_i         (wdata),
        .refill_line_i   (refill_line),
        .use_refill_i    (use_refill),
        .hit_o           (hit),
        .hit_way_o       (hit_way),
        .rd_word_o       (rd_word),
        .merge_line_o    (merge_line),
        .victim_line_o   (victim_line),
        .victim_status_o (victim_status)
    );

endmodule

// ==== logic/dcache_way.sv ====
module dcache_way (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  dcache_pkg::set_idx_t   set_i,
    input  dcache_pkg::tag_t       tag_i,
    input  logic                   we_i,
    input  dcache_pkg::line_t      line_i,
    input  logic                   dirty_i,
    output dcache_pkg::way_status_t status_o,
    output dcache_pkg::line_t      line_o
);

    // ==========================================================
    // Storage
    // ==========================================================
    dcache_pkg::tag_t  tag_mem  [dcache_pkg::N_SETS];
    dcache_pkg::line_t data_mem [dcache_pkg::N_SETS];
    logic [dcache_pkg::N_SETS-1:0] valid_q;  // Per set, cleared on reset
    logic [dcache_pkg::N_SETS-1:0] dirty_q;

    // Read port registers
    dcache_pkg::tag_t rd_tag_q;    // Stored tag of looked-up set
    dcache_pkg::tag_t cmp_tag_q;   // Tag of the access itself
    logic             rd_valid_q;
    logic             rd_dirty_q;

    // Tag and line written together
    always_ff @(posedge clk_i)
    begin
        if (we_i)
        begin
            tag_mem[set_i]  <= tag_i;
            data_mem[set_i] <= line_i;
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            valid_q <= '0;
            dirty_q <= '0;
        end
        else if (we_i)
        begin
            valid_q[set_i] <= 1'b1;
            dirty_q[set_i] <= dirty_i;  // Clean on read refill
        end
    end

    // One-cycle read, old data on a same-set write
    always_ff @(posedge clk_i)
    begin
        rd_tag_q   <= tag_mem[set_i];
        line_o     <= data_mem[set_i];
        cmp_tag_q  <= tag_i;
        rd_valid_q <= valid_q[set_i];
        rd_dirty_q <= dirty_q[set_i];
    end

    // Local tag compare
    assign status_o.hit   = rd_valid_q && (rd_tag_q == cmp_tag_q);
    assign status_o.dirty = rd_dirty_q;  // Never set without valid
    assign status_o.tag   = rd_tag_q;    // Victim tag for write-back address

endmodule

// ==== logic/dcache_way_select.sv ====
module dcache_way_select (
    input  dcache_pkg::way_status_t statuses_i [dcache_pkg::N_WAYS],
    input  dcache_pkg::line_t       lines_i    [dcache_pkg::N_WAYS],
    input  dcache_pkg::way_idx_t    victim_way_i,
    input  dcache_pkg::word_off_t   word_off_i,
    input  dcache_pkg::byte_en_t    byte_en_i,
    input  dcache_pkg::word_t       wdata_i,
    input  dcache_pkg::line_t       refill_line_i,
    input  logic                    use_refill_i,
    output logic                    hit_o,
    output dcache_pkg::way_idx_t    hit_way_o,
    output dcache_pkg::word_t       rd_word_o,
    output dcache_pkg::line_t       merge_line_o,
    output dcache_pkg::line_t       victim_line_o,
    output dcache_pkg::way_status_t victim_status_o
);

    dcache_pkg::line_t     base_line;    // Hit line or refill line
    dcache_pkg::word_off_t slot;         // Word slot counted from bit 0
    dcache_pkg::word_t     base_word;
    dcache_pkg::word_t     merged_word;

    // ==========================================================
    // Hit reduction
    // ==========================================================
    // At most one way matches a given set and tag
    always_comb
    begin
        hit_o     = 1'b0;
        hit_way_o = '0;
        for (int w = 0; w < dcache_pkg::N_WAYS; w++)
        begin
            if (statuses_i[w].hit)
            begin
                hit_o     = 1'b1;
                hit_way_o = dcache_pkg::way_idx_t'(w);
            end
        end
    end

    // ==========================================================
    // Word pick and byte merge
    // ==========================================================
    assign base_line = use_refill_i ? refill_line_i : lines_i[hit_way_o];

    // Offset 0 is the top word, so slot = 7 - offset
    assign slot      = ~word_off_i;
    assign base_word = base_line[slot * dcache_pkg::XLEN +: dcache_pkg::XLEN];
    assign rd_word_o = base_word;

    // Only enabled bytes replaced
    always_comb
    begin
        for (int b = 0; b < dcache_pkg::XLEN / 8; b++)
        begin
            merged_word[b*8 +: 8] = byte_en_i[b] ? wdata_i[b*8 +: 8] : base_word[b*8 +: 8];
        end
    end

    always_comb
    begin
        merge_line_o = base_line;
        merge_line_o[slot * dcache_pkg::XLEN +: dcache_pkg::XLEN] = merged_word;
    end

    // Victim for write-back
    assign victim_line_o   = lines_i[victim_way_i];
    assign victim_status_o = statuses_i[victim_way_i];

endmodule

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_dcache -Mdir obj_dir -o Vtb_dcache -f sim.f

./obj_dir/Vtb_dcache > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failed" sim.log || ! grep -q "Test passed" sim.log
then
    echo "Simulation FAILED, see sim.log"
    exit 1
fi
echo "Simulation finished cleanly"

// ==== sim.f ====
logic/dcache_pkg.sv
logic/dcache_way.sv
logic/dcache_way_select.sv
logic/dcache_ctrl.sv
logic/dcache_top.sv
testbench/dcache_sva.sv
testbench/tb_dcache.sv

// ==== testbench/dcache_sva.sv ====
module dcache_sva (
    input logic                    clk_i,
    input logic                    rst_i,
    input logic                    p_ready_i,
    input logic                    m_strobe_i,
    input dcache_pkg::mem_req_t    m_req_i,
    input logic                    m_ready_i,
    input dcache_pkg::ctrl_state_e state_i
);
    timeunit 1ns;
    timeprecision 1ps;

    // Memory request frozen while waiting for m_ready_i
    a_mem_req_held: assert property (@(posedge clk_i) disable iff (rst_i)
        m_strobe_i && !m_ready_i |=> m_strobe_i && $stable(m_req_i))
        else $error("memory request changed or dropped before m_ready_i");

    a_ready_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
        p_ready_i |=> !p_ready_i)  // One cycle only
        else $error("p_ready_o held for more than one cycle");

    // Memory is only touched during a miss
    a_idle_quiet: assert property (@(posedge clk_i) disable iff (rst_i)
        state_i == dcache_pkg::ST_IDLE |-> !m_strobe_i)
        else $error("m_strobe_o high in ST_IDLE");

endmodule

bind dcache_ctrl dcache_sva u_sva (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .p_ready_i  (p_ready_o),
    .m_strobe_i (m_strobe_o),
    .m_req_i    (m_req_o),
    .m_ready_i  (m_ready_i),
    .state_i    (state_q)
);

// ==== testbench/tb_dcache.sv ====
module tb_dcache;
    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        logic              rd;    // Only reads carry a checked value
        dcache_pkg::addr_t addr;
        dcache_pkg::word_t data;
    } expect_t;

    logic                 clk_i;
    logic                 rst_i;
    logic                 p_strobe_i;
    dcache_pkg::cpu_req_t p_req_i;
    logic                 p_ready_o;
    dcache_pkg::word_t    p_rdata_o;
    logic                 m_strobe_o;
    dcache_pkg::mem_req_t m_req_o;
    logic                 m_ready_i;
    dcache_pkg::line_t    m_rdata_i;

    dcache_pkg::word_t shadow [dcache_pkg::addr_t];     // Reference words, by word address
    dcache_pkg::line_t mem_lines [dcache_pkg::addr_t];  // Memory model, by line address
    expect_t           pending [$];
    int unsigned       mem_reads = 0;
    int unsigned       mem_writes = 0;
    int unsigned       resp_wait = 0;  // Cycles left before m_ready_i
    dcache_pkg::addr_t last_read_addr;
    dcache_pkg::addr_t last_wb_addr;

    dcache_top UUT (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .p_strobe_i (p_strobe_i),
        .p_req_i    (p_req_i),
        .p_ready_o  (p_ready_o),
        .p_rdata_o  (p_rdata_o),
        .m_strobe_o (m_strobe_o),
        .m_req_o    (m_req_o),
        .m_ready_i  (m_ready_i),
        .m_rdata_i  (m_rdata_i)
    );

    initial
    begin
        clk_i = 1'b0;
        forever
            #10 clk_i = ~clk_i;  // 20 ns period
    end

    // ==========================================================
    // Reference model
    // ==========================================================
    // Fill pattern over the whole word address
    function automatic dcache_pkg::word_t init_word(input dcache_pkg::addr_t addr);
        return (addr >> 2) * 32'h9E37_79B1 + 32'h0BAD_F00D;
    endfunction

    function automatic dcache_pkg::word_t expected_word(input dcache_pkg::addr_t addr);
        dcache_pkg::addr_t waddr;
        waddr = {addr[31:2], 2'b00};
        if (shadow.exists(waddr))
            return shadow[waddr];
        return init_word(waddr);
    endfunction

    function automatic dcache_pkg::word_t merge_bytes(input dcache_pkg::word_t old,
                                                      input dcache_pkg::word_t wdata,
                                                      input dcache_pkg::byte_en_t be);
        dcache_pkg::word_t res;
        res = old;
        for (int b = 0; b < 4; b++)
        begin
            if (be[b])
                res[b*8 +: 8] = wdata[b*8 +: 8];  // Enabled bytes only
        end
        return res;
    endfunction

    // Word 0 in the top 32 bits
    function automatic dcache_pkg::line_t expected_line(input dcache_pkg::addr_t line_addr);
        dcache_pkg::line_t line;
        for (int w = 0; w < 8; w++)
            line[(7 - w) * 32 +: 32] = expected_word(line_addr + 32'(w * 4));
        return line;
    endfunction

    function automatic dcache_pkg::line_t init_line(input dcache_pkg::addr_t line_addr);
        dcache_pkg::line_t line;
        for (int w = 0; w < 8; w++)
            line[(7 - w) * 32 +: 32] = init_word(line_addr + 32'(w * 4));
        return line;
    endfunction

    function automatic dcache_pkg::addr_t make_addr(input int unsigned tag,
                                                    input int unsigned set,
                                                    input int unsigned word);
        return {dcache_pkg::tag_t'(tag), dcache_pkg::set_idx_t'(set),
                dcache_pkg::word_off_t'(word), 2'b00};
    endfunction

    // ==========================================================
    // Failure reporting
    // ==========================================================
    task automatic end_with_failure();
        $display("Test failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_mismatch(input string msg);
        $display("** Error at %0d ns: %s", $time, msg);
        end_with_failure();
    endtask

    task automatic report_problem(input string msg);
        $display("%s", msg);
        end_with_failure();
    endtask

    task automatic next_cycle();
        @(posedge clk_i);
        #2;  // Drive point
    endtask

    // One access, returns edges from strobe to p_ready_o
    task automatic cpu_access(input logic rw, input dcache_pkg::addr_t addr,
                              input dcache_pkg::byte_en_t be, input dcache_pkg::word_t wdata,
                              output int unsigned cycles);
        expect_t entry;
        entry.rd   = !rw;
        entry.addr = addr;
        entry.data = expected_word(addr);
        pending.push_back(entry);
        if (rw)
            shadow[{addr[31:2], 2'b00}] = merge_bytes(expected_word(addr), wdata, be);
        p_strobe_i = 1'b1;
        p_req_i    = '{rw: rw, byte_en: be, addr: addr, wdata: wdata};
        next_cycle();
        p_strobe_i = 1'b0;
        cycles     = 1;
        while (!p_ready_o)
        begin
            if (cycles == 200)
                report_problem("Timeout: the cache gave no p_ready_o within 200 cycles");
            next_cycle();
            cycles++;
        end
        next_cycle();  // Cache back in ST_IDLE
    endtask

    // Memory side of one request, write-backs checked against the reference
    task automatic serve_memory();
        dcache_pkg::addr_t la;
        la = m_req_o.addr;
        if (m_req_o.rw)
        begin
            assert (m_req_o.line == expected_line(la))
            else report_mismatch($sformatf("write-back of line %h carries stale data", la));
            mem_lines[la] = m_req_o.line;
            mem_writes++;
            last_wb_addr = la;
        end
        else
        begin
            m_rdata_i = mem_lines.exists(la) ? mem_lines[la] : init_line(la);
            mem_reads++;
            last_read_addr = la;
        end
        m_ready_i = 1'b1;
    endtask

    // Memory model, 1 to 4 cycles per request
    initial
    begin
        forever
        begin
            next_cycle();
            if (m_ready_i)
                m_ready_i = 1'b0;  // Single-cycle pulse
            else if (m_strobe_o)
            begin
                if (resp_wait == 0)
                    resp_wait = $urandom_range(4, 1);
                resp_wait--;
                if (resp_wait == 0)
                    serve_memory();
            end
        end
    end

    // Checks every completed access
    initial
    begin
        expect_t entry;
        forever
        begin
            @(posedge clk_i);
            #1;
            if (p_ready_o)
            begin
                assert (pending.size() == 1)
                else report_problem("p_ready_o came without an outstanding request");
                entry = pending.pop_front();
                if (entry.rd)
                begin
                    assert (p_rdata_o == entry.data)
                    else report_mismatch($sformatf("read of %h returned %h, expected %h",
                                                   entry.addr, p_rdata_o, entry.data));
                end
            end
        end
    end

    // ==========================================================
    // Stimulus
    // ==========================================================
    initial
    begin
        int unsigned       cyc;
        int unsigned       r0;
        int unsigned       w0;
        dcache_pkg::addr_t a;
        void'($urandom(32'h1252));
        rst_i      = 1'b1;
        p_strobe_i = 1'b0;
        p_req_i    = '0;
        m_ready_i  = 1'b0;
        m_rdata_i  = '0;
        repeat (5) @(posedge clk_i);
        #2;
        rst_i = 1'b0;
        next_cycle();

        // Read miss to a fresh line
        r0 = mem_reads;
        a  = make_addr(32'h1A5, 2, 3);
        cpu_access(1'b0, a, 4'h0, '0, cyc);
        assert (mem_reads == r0 + 1 && last_read_addr == {a[31:5], 5'b0})
        else report_problem("Read miss did not cause exactly one line-aligned memory read");

        cpu_access(1'b1, a, 4'b0101, 32'hCAFE_BEEF, cyc);  // Partial write
        cpu_access(1'b0, a, 4'h0, '0, cyc);

        // Read hit in the resident line
        r0 = mem_reads;
        w0 = mem_writes;
        cpu_access(1'b0, make_addr(32'h1A5, 2, 6), 4'h0, '0, cyc);
        assert (cyc == 2)
        else report_mismatch($sformatf("read hit took %0d cycles, expected 2", cyc));
        assert (mem_reads == r0 && mem_writes == w0)
        else report_problem("Read hit caused a memory request");

        // Five tags in set 9, first one dirty
        for (int t = 0; t < 5; t++)
        begin
            w0 = mem_writes;
            cpu_access(t == 0, make_addr(32'h2000 + t, 9, 1), 4'hF, 32'h1111_0000 + t, cyc);
        end
        assert (mem_writes == w0 + 1 && last_wb_addr == make_addr(32'h2000, 9, 0))
        else report_problem("Fifth tag did not write back the first tag's line");
        r0 = mem_reads;
        cpu_access(1'b0, make_addr(32'h2000, 9, 1), 4'h0, '0, cyc);
        assert (mem_reads == r0 + 1)
        else report_problem("Evicted line was still found in the cache");

        // Random mix, 6 tags over 4 sets
        repeat (300)
        begin
            a = make_addr($urandom_range(5) + 32'h300, $urandom_range(3), $urandom_range(7));
            cpu_access(1'($urandom_range(1)), a, 4'($urandom), $urandom, cyc);
        end

        $display("Test passed");
        $finish;
    end

endmodule
